// ==== hnet_pkg.sv ====
package hnet_pkg;

	// Message field widths
	localparam int ADDR_W = 6;
	localparam int DAT_W  = 4;
	localparam int RED_W  = 4;

	// Bits covered by the redundancy code
	localparam int RED_FIELD_W = 2 * ADDR_W + DAT_W;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DAT_W-1:0]  dat_t;
	typedef logic [RED_W-1:0]  redun_t;

	// Fixed addresses of this network
	localparam addr_t MY_LOCAL_ADDR = 6'd5;   // This node
	localparam addr_t PRB_SRC_ADDR  = 6'd12;  // Expected probe source

	// Debounce of the incoming req
	localparam int REQ_CKS = 4;               // Equal samples before req is believed

	// Counter wide enough for the debounce and the startup delay
	localparam int CKS_W = $clog2(REQ_CKS + 2);

	typedef logic [CKS_W-1:0] cks_cnt_t;

	// Sequence register value when no word has been seen yet
	localparam dat_t DAT_NONE = 4'd15;

	// Message as it travels on a channel
	typedef struct packed {
		addr_t  src;
		addr_t  dst;
		dat_t   dat;
		redun_t red;
	} hnet_msg_t;

endpackage

// ==== hdbg_pkg.sv ====
package hdbg_pkg;

	import hnet_pkg::*;

	localparam int ERR_CODE_W = 3;

	// Reason of the first failing message
	typedef enum logic [ERR_CODE_W-1:0] {
		ERR_NONE = 3'd0,
		ERR_DST  = 3'd1,   // Wrong destination
		ERR_SRC  = 3'd2,   // Unexpected source
		ERR_RED  = 3'd3,   // Redundancy mismatch
		ERR_SEQ  = 3'd4    // Data word out of sequence
	} err_code_e;

	// Sticky error record of a node
	typedef struct packed {
		logic      valid;
		err_code_e code;
		hnet_msg_t msg;
		addr_t     node;
	} dbg_err_t;

endpackage

// ==== calc_redun.sv ====
`timescale 1ns/100ps

module calc_redun
	import hnet_pkg::*;
(
	input  hnet_msg_t msg,
	output redun_t    redun
);

	logic [RED_FIELD_W-1:0] fld_bits;
	logic [RED_W:0]         ones;

	assign fld_bits = {msg.src, msg.dst, msg.dat};  // Code field left out

	// Population count of the covered fields
	always_comb begin
		ones = '0;
		for (int i = 0; i < RED_FIELD_W; i++) begin
			ones = ones + fld_bits[i];
		end
	end

	assign redun = ones[RED_W-1:0];  // Modulo 16

endmodule

// ==== hreq_sync.sv ====
`timescale 1ns/100ps

module hreq_sync
	import hnet_pkg::*;
(
	input  logic snk0_clk,
	input  logic gch_reset,
	input  logic req,
	output logic req_ckd,
	output logic sync_rdy
);

	logic     req_s1;
	logic     req_s2;
	logic     ckd_q;
	cks_cnt_t stb_cnt;
	logic     rdy_q;
	cks_cnt_t rdy_cnt;

	// Two-flop synchroniser
	always_ff @(posedge snk0_clk) begin
		if (gch_reset) begin
			req_s1 <= 1'b0;
			req_s2 <= 1'b0;
		end else begin
			req_s1 <= req;
			req_s2 <= req_s1;
		end
	end

	// Counts consecutive samples that disagree with the believed level
	always_ff @(posedge snk0_clk) begin
		if (gch_reset) begin
			ckd_q   <= 1'b0;
			stb_cnt <= '0;
		end else if (req_s2 == ckd_q) begin
			stb_cnt <= '0;  // Glitch gone, start over
		end else if (stb_cnt == cks_cnt_t'(REQ_CKS - 1)) begin
			ckd_q   <= req_s2;
			stb_cnt <= '0;
		end else begin
			stb_cnt <= stb_cnt + 1'b1;
		end
	end

	// Ready once the pipeline above has filled
	always_ff @(posedge snk0_clk) begin
		if (gch_reset) begin
			rdy_q   <= 1'b0;
			rdy_cnt <= '0;
		end else if (rdy_cnt == cks_cnt_t'(REQ_CKS + 1)) begin
			rdy_q <= 1'b1;
		end else begin
			rdy_cnt <= rdy_cnt + 1'b1;
		end
	end

	assign req_ckd  = ckd_q;
	assign sync_rdy = rdy_q;

	// The debounced level holds at least one cycle after each change
	ckd_no_toggle: assert property (@(posedge snk0_clk) disable iff (gch_reset)
		$changed(ckd_q) |=> $stable(ckd_q))
		else $error("req_ckd changed on two consecutive cycles");

endmodule

// ==== hprg_sink.sv ====
`timescale 1ns/100ps

module hprg_sink
	import hnet_pkg::*, hdbg_pkg::*;
(
	input  logic      snk0_clk,
	input  logic      gch_reset,
	input  logic      req_ckd,
	input  hnet_msg_t msg,
	input  redun_t    calc_red,
	output hnet_msg_t held_msg,
	output logic      ack,
	output logic      rdy,
	output dbg_err_t  err0
);

	logic      rdy_q;
	logic      has_inp;
	logic      has_redun;
	logic      done_cks;
	logic      ack_q;
	dat_t      back_dat;
	hnet_msg_t inp_msg;
	redun_t    inp_redun;

	logic      err_vld;
	err_code_e err_code;
	hnet_msg_t err_msg;

	logic      busy;
	logic      cap_en;
	logic      red_en;
	logic      chk_en;
	logic      seq_ok;
	err_code_e chk_code;

	// A message is worked on while req is up and not yet acknowledged
	assign busy   = rdy_q && req_ckd && !ack_q;
	assign cap_en = busy && !has_inp;
	assign red_en = busy && has_inp && !has_redun;
	assign chk_en = busy && has_inp && has_redun && !done_cks;

	// Sequence only checked once a previous word is known
	always_comb begin
		seq_ok = (back_dat == DAT_NONE) || (inp_msg.dat == dat_t'(back_dat + 1'b1));
	end

	// Checks in priority order
	always_comb begin
		if (inp_msg.dst != MY_LOCAL_ADDR) begin
			chk_code = ERR_DST;
		end else if (inp_msg.src != PRB_SRC_ADDR) begin
			chk_code = ERR_SRC;
		end else if (inp_msg.red != inp_redun) begin
			chk_code = ERR_RED;
		end else if (!seq_ok) begin
			chk_code = ERR_SEQ;
		end else begin
			chk_code = ERR_NONE;
		end
	end

	// Handshake and stage flags
	always_ff @(posedge snk0_clk) begin
		if (gch_reset) begin
			rdy_q     <= 1'b0;
			has_inp   <= 1'b0;
			has_redun <= 1'b0;
			done_cks  <= 1'b0;
			ack_q     <= 1'b0;
		end else if (!rdy_q) begin
			rdy_q <= 1'b1;  // Init step
		end else if (req_ckd && !ack_q) begin
			if (!has_inp) begin
				has_inp <= 1'b1;
			end else if (!has_redun) begin
				has_redun <= 1'b1;
			end else if (!done_cks) begin
				done_cks <= 1'b1;
			end else begin
				has_inp   <= 1'b0;
				has_redun <= 1'b0;
				done_cks  <= 1'b0;
				ack_q     <= 1'b1;
			end
		end else if (!req_ckd && ack_q) begin
			ack_q <= 1'b0;
		end
	end

	// Sequence register and sticky error state
	always_ff @(posedge snk0_clk) begin
		if (gch_reset) begin
			err_vld  <= 1'b0;
			err_code <= ERR_NONE;
			back_dat <= DAT_NONE;
		end else if (!rdy_q) begin
			back_dat <= DAT_NONE;  // Fresh sequence after init
		end else if (chk_en && !err_vld) begin
			if (chk_code != ERR_NONE) begin
				err_vld  <= 1'b1;
				err_code <= chk_code;
			end else begin
				back_dat <= inp_msg.dat;
			end
		end
	end

	// Message payloads
	always_ff @(posedge snk0_clk) begin
		if (cap_en) begin
			inp_msg <= msg;
		end
		if (red_en) begin
			inp_redun <= calc_red;  // Code of the captured message
		end
		if (chk_en && !err_vld && chk_code != ERR_NONE) begin
			err_msg <= inp_msg;
		end
	end

	assign held_msg = inp_msg;
	assign ack      = ack_q;
	assign rdy      = rdy_q;

	assign err0 = '{
		valid: err_vld,
		code:  err_code,
		msg:   err_msg,
		node:  MY_LOCAL_ADDR
	};

	// Ack only answers a believed req
	ack_needs_req: assert property (@(posedge snk0_clk) disable iff (gch_reset)
		$rose(ack_q) |-> $past(req_ckd))
		else $error("ack rose while req_ckd was low");

	// The error record is sticky until reset
	err_sticky: assert property (@(posedge snk0_clk) disable iff (gch_reset)
		err_vld |=> err_vld)
		else $error("err0.valid fell outside reset");

endmodule

// ==== hsink_node.sv ====
`timescale 1ns/100ps

module hsink_node
	import hnet_pkg::*, hdbg_pkg::*;
(
	input  logic      snk0_clk,
	input  logic      gch_reset,
	input  logic      rcv0_req,
	input  hnet_msg_t rcv0_msg,
	output logic      rcv0_ack,
	output logic      gch_ready,
	output dbg_err_t  err0
);

	logic      req_ckd;
	logic      sync_rdy;
	logic      snk_rdy;
	hnet_msg_t held_msg;
	redun_t    calc_red;

	// Incoming req cleaned up before the sink sees it
	hreq_sync sync0 (
		.snk0_clk (snk0_clk),
		.gch_reset(gch_reset),
		.req      (rcv0_req),
		.req_ckd  (req_ckd),
		.sync_rdy (sync_rdy)
	);

	hprg_sink sink0 (
		.snk0_clk (snk0_clk),
		.gch_reset(gch_reset),
		.req_ckd  (req_ckd),
		.msg      (rcv0_msg),
		.calc_red (calc_red),
		.held_msg (held_msg),
		.ack      (rcv0_ack),
		.rdy      (snk_rdy),
		.err0     (err0)
	);

	// Code recomputed from the captured copy
	calc_redun red0 (
		.msg  (held_msg),
		.redun(calc_red)
	);

	assign gch_ready = sync_rdy && snk_rdy;

endmodule

// ==== tb_hsink_checker.sv ====
`timescale 1ns/100ps

module tb_hsink_checker
	import hnet_pkg::*, hdbg_pkg::*;
(
	input  logic      snk0_clk,
	input  logic      gch_reset,
	input  logic      rcv0_req,
	input  hnet_msg_t rcv0_msg,
	input  logic      rcv0_ack,
	input  logic      gch_ready,
	input  dbg_err_t  err0,
	input  err_code_e exp_code,
	output int        val_errs,
	output int        proto_errs
);

	int        cyc = 0;
	int        rise_cyc = 0;
	int        fall_cyc = 0;
	logic      prev_req = 1'b0;
	logic      prev_ack = 1'b0;
	logic      pending = 1'b0;
	logic      ready_seen = 1'b0;
	logic      in_reset = 1'b0;
	hnet_msg_t cur_msg;
	err_code_e got_code;

	// Reference model of the sink state
	dat_t      m_back = DAT_NONE;
	logic      m_vld = 1'b0;
	err_code_e m_code = ERR_NONE;
	hnet_msg_t m_msg;

	initial begin
		val_errs   = 0;
		proto_errs = 0;
	end

	function automatic redun_t count_ones(input hnet_msg_t m);
		logic [RED_FIELD_W-1:0] bits;
		int n;
		bits = {m.src, m.dst, m.dat};
		n = 0;
		for (int i = 0; i < RED_FIELD_W; i++) begin
			n = n + bits[i];
		end
		return redun_t'(n % 16);
	endfunction

	task automatic value_err(input string name, input logic [31:0] got, input logic [31:0] exp);
		$display("ERR t=%0t %s got %0h expected %0h", $time, name, got, exp);
		val_errs++;
	endtask

	task automatic proto_err(input string what);
		$display("t=%0t %s", $time, what);
		proto_errs++;
	endtask

	// First failure wins, DST before SRC before RED before SEQ
	task automatic apply_model(input hnet_msg_t m);
		err_code_e code;
		if (m.dst != MY_LOCAL_ADDR) begin
			code = ERR_DST;
		end else if (m.src != PRB_SRC_ADDR) begin
			code = ERR_SRC;
		end else if (m.red != count_ones(m)) begin
			code = ERR_RED;
		end else if (m_back <= 4'd14 && m.dat != dat_t'(m_back + 4'd1)) begin
			code = ERR_SEQ;
		end else begin
			code = ERR_NONE;
		end
		if (code != ERR_NONE) begin
			m_vld  = 1'b1;
			m_code = code;
			m_msg  = m;
		end else begin
			m_back = m.dat;
		end
	endtask

	task automatic compare_record();
		if (err0.valid !== m_vld)
			value_err("err0.valid", err0.valid, m_vld);
		if (err0.node !== MY_LOCAL_ADDR)
			value_err("err0.node", err0.node, MY_LOCAL_ADDR);
		if (m_vld && err0.code !== m_code)
			value_err("err0.code", err0.code, m_code);
		if (m_vld && err0.msg !== m_msg)
			value_err("err0.msg", err0.msg, m_msg);
	endtask

	always @(posedge snk0_clk) begin
		cyc++;
		if (gch_reset) begin
			m_back     = DAT_NONE;
			m_vld      = 1'b0;
			m_code     = ERR_NONE;
			pending    = 1'b0;
			ready_seen = 1'b0;
			in_reset   = 1'b1;
		end else begin
			if (in_reset && rcv0_ack !== 1'b0)
				value_err("rcv0_ack", rcv0_ack, 1'b0);  // Out of reset
			if (in_reset && gch_ready !== 1'b0)
				value_err("gch_ready", gch_ready, 1'b0);
			in_reset = 1'b0;
			if (gch_ready) begin
				ready_seen = 1'b1;
			end else if (ready_seen) begin
				proto_err("gch_ready fell again after it had risen");
			end
			if (rcv0_req && !prev_req) begin
				rise_cyc = cyc;
				cur_msg  = rcv0_msg;
				pending  = 1'b1;
			end
			if (rcv0_ack && !prev_ack) begin
				if (!pending) begin
					proto_err("ack rose without a message waiting for it");
				end else begin
					pending = 1'b0;
					if (cyc - rise_cyc != REQ_CKS + 6)
						value_err("ack rise latency", cyc - rise_cyc, REQ_CKS + 6);
					if (!m_vld)
						apply_model(cur_msg);
					got_code = err0.valid ? err0.code : ERR_NONE;
					if (got_code !== exp_code)
						value_err("err0.code vs table", got_code, exp_code);
				end
			end
			if (!rcv0_req && prev_req) begin
				fall_cyc = cyc;
				pending  = 1'b0;  // Glitch if still pending
			end
			if (!rcv0_ack && prev_ack && cyc - fall_cyc != REQ_CKS + 3)
				value_err("ack fall latency", cyc - fall_cyc, REQ_CKS + 3);
			if (rcv0_ack || !rcv0_req)
				compare_record();  // Only while no message is in the pipe
		end
		prev_req = rcv0_req;
		prev_ack = rcv0_ack;
	end

endmodule

// ==== tb_hsink_node.sv ====
`timescale 1ns/100ps

module tb_hsink_node
	import hnet_pkg::*, hdbg_pkg::*;
;

	typedef struct packed {
		addr_t     src;
		addr_t     dst;
		dat_t      dat;
		logic      corrupt_red;
		logic      reset_first;
		err_code_e exp_code;  // Record code after this message
	} stim_row_t;

	localparam int N_ROWS  = 17;
	localparam int MAX_CYC = N_ROWS * (2 * REQ_CKS + 20) + 100;

	logic      snk0_clk = 1'b0;
	logic      gch_reset;
	logic      rcv0_req;
	hnet_msg_t rcv0_msg;
	logic      rcv0_ack;
	logic      gch_ready;
	dbg_err_t  err0;
	err_code_e exp_code;
	int        val_errs;
	int        proto_errs;
	int        run_cyc = 0;
	int        seed = 61;
	stim_row_t rows [N_ROWS];

	hsink_node dut0 (
		.snk0_clk (snk0_clk),
		.gch_reset(gch_reset),
		.rcv0_req (rcv0_req),
		.rcv0_msg (rcv0_msg),
		.rcv0_ack (rcv0_ack),
		.gch_ready(gch_ready),
		.err0     (err0)
	);

	tb_hsink_checker chk0 (
		.snk0_clk  (snk0_clk),
		.gch_reset (gch_reset),
		.rcv0_req  (rcv0_req),
		.rcv0_msg  (rcv0_msg),
		.rcv0_ack  (rcv0_ack),
		.gch_ready (gch_ready),
		.err0      (err0),
		.exp_code  (exp_code),
		.val_errs  (val_errs),
		.proto_errs(proto_errs)
	);

	always #2 snk0_clk = ~snk0_clk;

	always @(posedge snk0_clk) begin
		run_cyc++;
		if (run_cyc >= MAX_CYC) begin
			$display("Timeout after %0d cycles, the handshake never completed", run_cyc);
			$display("Errors: value %0d, other %0d", val_errs, proto_errs + 1);
			$display("** FAIL **");
			$finish;
		end
	end

	function automatic redun_t good_red(input addr_t src, input addr_t dst, input dat_t dat);
		logic [RED_FIELD_W-1:0] bits;
		int n;
		bits = {src, dst, dat};
		n = 0;
		for (int i = 0; i < RED_FIELD_W; i++) begin
			n = n + bits[i];
		end
		return redun_t'(n % 16);
	endfunction

	task automatic set_row(input int i, input addr_t src, input addr_t dst, input dat_t dat,
		input logic cr, input logic rf, input err_code_e code);
		rows[i].src         = src;
		rows[i].dst         = dst;
		rows[i].dat         = dat;
		rows[i].corrupt_red = cr;
		rows[i].reset_first = rf;
		rows[i].exp_code    = code;
	endtask

	task automatic fill_table();
		set_row(0, PRB_SRC_ADDR, MY_LOCAL_ADDR, 4'd13, 1'b0, 1'b0, ERR_NONE);
		set_row(1, PRB_SRC_ADDR, MY_LOCAL_ADDR, 4'd14, 1'b0, 1'b0, ERR_NONE);
		set_row(2, PRB_SRC_ADDR, MY_LOCAL_ADDR, 4'd15, 1'b0, 1'b0, ERR_NONE);
		set_row(3, PRB_SRC_ADDR, MY_LOCAL_ADDR, 4'd0, 1'b0, 1'b0, ERR_NONE);   // Wrap
		set_row(4, PRB_SRC_ADDR, MY_LOCAL_ADDR, 4'd1, 1'b0, 1'b0, ERR_NONE);
		set_row(5, PRB_SRC_ADDR, 6'd7, 4'd2, 1'b1, 1'b0, ERR_DST);             // DST over RED
		set_row(6, 6'd9, MY_LOCAL_ADDR, 4'd3, 1'b1, 1'b1, ERR_SRC);            // SRC over RED
		set_row(7, PRB_SRC_ADDR, 6'd7, 4'd5, 1'b0, 1'b0, ERR_SRC);             // Record holds
		set_row(8, PRB_SRC_ADDR, MY_LOCAL_ADDR, 4'd8, 1'b0, 1'b1, ERR_NONE);
		set_row(9, PRB_SRC_ADDR, MY_LOCAL_ADDR, 4'd11, 1'b1, 1'b0, ERR_RED);   // RED over SEQ
		set_row(10, PRB_SRC_ADDR, MY_LOCAL_ADDR, 4'd12, 1'b0, 1'b0, ERR_RED);
		set_row(11, PRB_SRC_ADDR, MY_LOCAL_ADDR, 4'd2, 1'b0, 1'b1, ERR_NONE);
		set_row(12, PRB_SRC_ADDR, MY_LOCAL_ADDR, 4'd3, 1'b0, 1'b0, ERR_NONE);
		set_row(13, PRB_SRC_ADDR, MY_LOCAL_ADDR, 4'd5, 1'b0, 1'b0, ERR_SEQ);   // Skipped word
		set_row(14, PRB_SRC_ADDR, MY_LOCAL_ADDR, 4'd6, 1'b0, 1'b0, ERR_SEQ);
		set_row(15, PRB_SRC_ADDR, MY_LOCAL_ADDR, 4'd0, 1'b0, 1'b1, ERR_NONE);  // Reset clears
		set_row(16, PRB_SRC_ADDR, MY_LOCAL_ADDR, 4'd1, 1'b0, 1'b0, ERR_NONE);
	endtask

	task automatic apply_reset();
		gch_reset = 1'b1;
		repeat (3) @(negedge snk0_clk);
		gch_reset = 1'b0;
	endtask

	// Four-phase sender, always entered on a falling edge
	task automatic send_row(input stim_row_t r);
		hnet_msg_t m;
		int idle;
		if (r.reset_first)
			apply_reset();
		while (!gch_ready) @(negedge snk0_clk);
		m.src    = r.src;
		m.dst    = r.dst;
		m.dat    = r.dat;
		m.red    = good_red(r.src, r.dst, r.dat) ^ redun_t'(r.corrupt_red);
		rcv0_msg = m;
		exp_code = r.exp_code;
		rcv0_req = 1'b1;
		while (!rcv0_ack) @(negedge snk0_clk);
		rcv0_req = 1'b0;
		while (rcv0_ack) @(negedge snk0_clk);
		idle = $unsigned($random(seed)) % 4;
		repeat (idle) @(negedge snk0_clk);
	endtask

	// Short req pulse that the debouncer must swallow
	task automatic req_glitch();
		rcv0_req = 1'b1;
		repeat (REQ_CKS - 2) @(negedge snk0_clk);
		rcv0_req = 1'b0;
		repeat (2 * REQ_CKS + 6) @(negedge snk0_clk);
	endtask

	initial begin
		gch_reset = 1'b1;
		rcv0_req  = 1'b0;
		rcv0_msg  = '0;
		exp_code  = ERR_NONE;
		fill_table();
		repeat (3) @(negedge snk0_clk);
		gch_reset = 1'b0;
		for (int i = 0; i < N_ROWS; i++) begin
			send_row(rows[i]);
		end
		req_glitch();
		repeat (4) @(negedge snk0_clk);
		$display("Errors: value %0d, other %0d", val_errs, proto_errs);
		if (val_errs == 0 && proto_errs == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// ==== files.f ====
hnet_pkg.sv
hdbg_pkg.sv
calc_redun.sv
hreq_sync.sv
hprg_sink.sv
hsink_node.sv
tb_hsink_checker.sv
tb_hsink_node.sv

// ==== Bender.yml ====
package:
  name: hsink_node

sources:
  - hnet_pkg.sv
  - hdbg_pkg.sv
  - calc_redun.sv
  - hreq_sync.sv
  - hprg_sink.sv
  - hsink_node.sv
  - target: test
    files:
      - tb_hsink_checker.sv
      - tb_hsink_node.sv
